//--- verilog/dmem_config.svh
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// Byte address and data word widths
`define DMEM_ADDR_W 32
`define DMEM_DATA_W 32

// 1024 words, 4 KiB
`define DMEM_DEPTH_LOG2 10

`endif

//--- verilog/dmem_pkg.sv
`include "dmem_config.svh"

package dmem_pkg;

    // Access size as carried on the simple bus
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10,
        MEM_RSVD = 2'b11 // Always faults
    } mem_size_e;

    // Address error report from the bridge
    typedef struct packed {
        logic                    adel; // Load address error
        logic                    ades; // Store address error
        logic [`DMEM_ADDR_W-1:0] addr; // Faulting byte address
    } bus_error_t;

    // One loaded word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } load_word_u;

endpackage

//--- verilog/sbus_if.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

interface sbus_if import dmem_pkg::*; ();

    logic                    en;
    logic                    we;
    mem_size_e               size;
    logic [`DMEM_ADDR_W-1:0] addr;
    logic [`DMEM_DATA_W-1:0] data_w;
    logic [`DMEM_DATA_W-1:0] data_r; // Realigned toward bit 0
    logic                    stall;

    modport master (
        output en, we, size, addr, data_w,
        input  data_r, stall
    );

    modport slave (
        input  en, we, size, addr, data_w,
        output data_r, stall
    );

endinterface

//--- verilog/lsu_request.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

module lsu_request import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic                    req_store,
    input  mem_size_e               req_size,
    input  logic                    req_signed,
    input  logic [`DMEM_ADDR_W-1:0] req_addr,
    input  logic [`DMEM_DATA_W-1:0] req_wdata,
    sbus_if.master                  bus,
    output mem_size_e               acc_size,
    output logic                    acc_signed
);

    logic                    en_q;
    logic                    we_q;
    mem_size_e               size_q;
    logic                    signed_q;
    logic [`DMEM_ADDR_W-1:0] addr_q;
    logic [`DMEM_DATA_W-1:0] wdata_q;

    // One bus cycle per strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            en_q <= 1'b0;
            we_q <= 1'b0;
        end else begin
            en_q <= req_valid;
            we_q <= req_valid & req_store;
        end
    end

    // Payload only moves on a new request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            size_q   <= req_size;
            signed_q <= req_signed;
            addr_q   <= req_addr;
            wdata_q  <= req_wdata;
        end
    end

    assign bus.en     = en_q;
    assign bus.we     = we_q;
    assign bus.size   = size_q;
    assign bus.addr   = addr_q;
    assign bus.data_w = wdata_q;

    // Extension info for the response side
    assign acc_size   = size_q;
    assign acc_signed = signed_q;

    // No wait states on this path, the strobe handshake cannot hold a request
    a_no_stall: assert property (
        @(posedge clk) disable iff (rst) bus.en |-> !bus.stall
    );

endmodule

//--- verilog/sbus_to_sram.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

module sbus_to_sram import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    sbus_if.slave                   sbus,
    output logic                    sram_en,
    output logic [3:0]              sram_we,
    output logic [`DMEM_ADDR_W-1:0] sram_addr,
    output logic [`DMEM_DATA_W-1:0] sram_wdata,
    input  logic [`DMEM_DATA_W-1:0] sram_rdata,
    output bus_error_t              sbus_error
);

    logic [3:0] mask;
    logic [3:0] rd_mask; // Mask of the access now being read

    // Byte lanes touched by this access
    always_comb begin
        mask = 4'b0000;
        case (sbus.size)
            MEM_BYTE: mask = 4'b0001 << sbus.addr[1:0];
            MEM_HALF: begin
                if (!sbus.addr[0]) begin
                    mask = sbus.addr[1] ? 4'b1100 : 4'b0011;
                end
            end
            MEM_WORD: begin
                if (sbus.addr[1:0] == 2'b00) begin
                    mask = 4'b1111;
                end
            end
            default: mask = 4'b0000; // Reserved size
        endcase
    end

    assign sram_en   = sbus.en;
    assign sram_we   = sbus.we ? mask : 4'b0000;
    assign sram_addr = {sbus.addr[`DMEM_ADDR_W-1:2], 2'b00};

    // Move store data up to the lowest enabled lane
    always_comb begin
        if (mask[2:0] == 3'b000) begin
            sram_wdata = sbus.data_w << 24;
        end else if (mask[1:0] == 2'b00) begin
            sram_wdata = sbus.data_w << 16;
        end else if (!mask[0]) begin
            sram_wdata = sbus.data_w << 8;
        end else begin
            sram_wdata = sbus.data_w;
        end
    end

    // SRAM answers one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_mask <= 4'b0000;
        end else begin
            rd_mask <= mask;
        end
    end

    assign sbus.data_r = (rd_mask[2:0] == 3'b000) ? sram_rdata >> 24 :
                         (rd_mask[1:0] == 2'b00)  ? sram_rdata >> 16 :
                         (!rd_mask[0])            ? sram_rdata >> 8  :
                                                    sram_rdata;

    assign sbus.stall = 1'b0;

    // Empty mask means misaligned or reserved size
    assign sbus_error.adel = sbus.en && (mask == 4'b0000) && !sbus.we;
    assign sbus_error.ades = sbus.en && (mask == 4'b0000) && sbus.we;
    assign sbus_error.addr = sbus.addr;

    a_we_needs_en: assert property (
        @(posedge clk) disable iff (rst) (sram_we != 4'b0000) |-> sram_en
    );

endmodule

//--- verilog/sram_bank.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

module sram_bank (
    input  logic                    clk,
    input  logic                    en,
    input  logic [3:0]              we,
    input  logic [`DMEM_ADDR_W-1:0] addr,
    input  logic [`DMEM_DATA_W-1:0] wdata,
    output logic [`DMEM_DATA_W-1:0] rdata
);

    localparam int DEPTH = 2 ** `DMEM_DEPTH_LOG2;

    logic [`DMEM_DATA_W-1:0]     mem [DEPTH];
    logic [`DMEM_DEPTH_LOG2-1:0] idx;

    // Word index, byte offset dropped
    assign idx = addr[`DMEM_DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (we[lane]) begin
                    mem[idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read returns the word as it was before this edge's write
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
        end
    end

endmodule

//--- verilog/load_align.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

module load_align import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`DMEM_DATA_W-1:0] data_r,
    input  mem_size_e               acc_size,
    input  logic                    acc_signed,
    input  logic                    acc_en,
    input  logic                    acc_we,
    input  logic                    load_fault,
    output logic                    rsp_valid,
    output logic [`DMEM_DATA_W-1:0] rsp_data
);

    logic                    ld_pend; // Good load waiting on SRAM data
    mem_size_e               size_q;
    logic                    signed_q;
    load_word_u              word;
    logic [`DMEM_DATA_W-1:0] ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_pend   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            ld_pend   <= acc_en && !acc_we && !load_fault;
            rsp_valid <= ld_pend;
        end
    end

    always_ff @(posedge clk) begin
        size_q   <= acc_size;
        signed_q <= acc_signed;
    end

    assign word = data_r;

    always_comb begin
        case (size_q)
            MEM_BYTE: ext = {{24{signed_q & word.b[0][7]}}, word.b[0]};
            MEM_HALF: ext = {{16{signed_q & word.h[0][15]}}, word.h[0]};
            default:  ext = word; // Full word, nothing to extend
        endcase
    end

    always_ff @(posedge clk) begin
        if (ld_pend) begin
            rsp_data <= ext;
        end
    end

endmodule

//--- verilog/dmem_top.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

module dmem_top import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic                    req_store,
    input  mem_size_e               req_size,
    input  logic                    req_signed,
    input  logic [`DMEM_ADDR_W-1:0] req_addr,
    input  logic [`DMEM_DATA_W-1:0] req_wdata,
    output logic                    rsp_valid,
    output logic [`DMEM_DATA_W-1:0] rsp_data,
    output logic                    err_load,
    output logic                    err_store,
    output logic [`DMEM_ADDR_W-1:0] err_addr
);

    sbus_if bus ();

    mem_size_e               acc_size;
    logic                    acc_signed;
    logic                    sram_en;
    logic [3:0]              sram_we;
    logic [`DMEM_ADDR_W-1:0] sram_addr;
    logic [`DMEM_DATA_W-1:0] sram_wdata;
    logic [`DMEM_DATA_W-1:0] sram_rdata;
    bus_error_t              sbus_error;

    lsu_request lsu_request_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_store  (req_store),
        .req_size   (req_size),
        .req_signed (req_signed),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .bus        (bus.master),
        .acc_size   (acc_size),
        .acc_signed (acc_signed)
    );

    sbus_to_sram sbus_to_sram_i (
        .clk        (clk),
        .rst        (rst),
        .sbus       (bus.slave),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .sbus_error (sbus_error)
    );

    sram_bank sram_bank_i (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    load_align load_align_i (
        .clk        (clk),
        .rst        (rst),
        .data_r     (bus.data_r),
        .acc_size   (acc_size),
        .acc_signed (acc_signed),
        .acc_en     (bus.en),
        .acc_we     (bus.we),
        .load_fault (sbus_error.adel),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    // Error report, valid in the bus cycle only
    assign err_load  = sbus_error.adel;
    assign err_store = sbus_error.ades;
    assign err_addr  = sbus_error.addr;

endmodule

//--- verif/dmem_checker.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

module dmem_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rsp_valid,
    input  logic [`DMEM_DATA_W-1:0] rsp_data,
    input  logic                    err_load,
    input  logic                    err_store,
    input  logic [`DMEM_ADDR_W-1:0] err_addr,
    input  logic                    exp_rsp,
    input  logic                    exp_err,
    input  logic                    exp_store,
    input  logic [31:0]             exp_value,
    input  int                      exp_id,
    input  logic                    report,
    output int                      pending,
    output int                      tests_run,
    output int                      error_count
);

    typedef struct packed {
        int          id;
        int          due; // Edge that must see the strobe
        logic [31:0] value;
        logic        store;
    } exp_t;

    exp_t rsp_q[$];
    exp_t err_q[$];
    int   cycle    = 0;
    int   failed   = 0;
    int   stray    = 0;
    logic reported = 1'b0;

    task automatic check_rsp(input exp_t e);
        tests_run++;
        if (cycle != e.due) begin
            $display("Test %0d failed because its load response came %0d cycles early",
                     e.id, e.due - cycle);
            failed++;
        end else if (rsp_data === e.value) begin
            $display("[PASS] test %0d load data 0x%08h", e.id, rsp_data);
        end else begin
            $display("[FAIL] rsp_data expected 0x%08h got 0x%08h (test %0d)",
                     e.value, rsp_data, e.id);
            failed++;
        end
    endtask

    task automatic check_err(input exp_t e);
        logic ok;
        ok = (err_load === !e.store) && (err_store === e.store);
        tests_run++;
        if (!ok) begin
            $display("[FAIL] err_load/err_store expected 0x%0h/0x%0h got 0x%0h/0x%0h (test %0d)",
                     !e.store, e.store, err_load, err_store, e.id);
        end
        if (err_addr !== e.value) begin
            $display("[FAIL] err_addr expected 0x%08h got 0x%08h (test %0d)",
                     e.value, err_addr, e.id);
            ok = 1'b0;
        end
        if (ok) begin
            $display("[PASS] test %0d %s address error at 0x%08h", e.id,
                     e.store ? "store" : "load", err_addr);
        end else begin
            failed++;
        end
    endtask

    always @(posedge clk) begin
        exp_t e;
        if (!rst) begin
            if (rsp_valid && rsp_q.size() == 0) begin
                $display("Unexpected load response with data 0x%08h", rsp_data);
                stray++;
            end else if (rsp_valid) begin
                e = rsp_q.pop_front();
                check_rsp(e);
            end
            if ((err_load || err_store) && err_q.size() == 0) begin
                $display("Unexpected address error strobe at 0x%08h", err_addr);
                stray++;
            end else if (err_load || err_store) begin
                e = err_q.pop_front();
                check_err(e);
            end
            // At most one entry per queue falls due each cycle
            if (rsp_q.size() > 0 && rsp_q[0].due <= cycle) begin
                e = rsp_q.pop_front();
                $display("Test %0d failed because its load response never came", e.id);
                tests_run++;
                failed++;
            end
            if (err_q.size() > 0 && err_q[0].due <= cycle) begin
                e = err_q.pop_front();
                $display("Test %0d failed because its address error never came", e.id);
                tests_run++;
                failed++;
            end
            if (exp_rsp) begin
                rsp_q.push_back({exp_id, cycle + 3, exp_value, 1'b0});
            end
            if (exp_err) begin
                err_q.push_back({exp_id, cycle + 1, exp_value, exp_store});
            end
            cycle++;
            if (report && !reported) begin
                $display("Totals: %0d tests run, %0d failed, %0d unexpected strobes",
                         tests_run, failed, stray);
                reported = 1'b1;
            end
        end
        pending     = rsp_q.size() + err_q.size();
        error_count = failed + stray;
    end

endmodule

//--- verif/dmem_tb.sv
`timescale 1ns/10ps
`include "dmem_config.svh"

module dmem_tb import dmem_pkg::*; ();

    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 8;
    localparam int MARGIN     = 20;

    localparam logic [1:0] OUT_NONE = 2'd0;
    localparam logic [1:0] OUT_DATA = 2'd1;
    localparam logic [1:0] OUT_ERR  = 2'd2;

    typedef struct packed {
        logic        store;
        logic [1:0]  size;
        logic        sgn;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  outcome;
        logic [31:0] value; // Load result or faulting address
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    req_valid;
    logic                    req_store;
    mem_size_e               req_size;
    logic                    req_signed;
    logic [`DMEM_ADDR_W-1:0] req_addr;
    logic [`DMEM_DATA_W-1:0] req_wdata;
    logic                    rsp_valid;
    logic [`DMEM_DATA_W-1:0] rsp_data;
    logic                    err_load;
    logic                    err_store;
    logic [`DMEM_ADDR_W-1:0] err_addr;
    logic                    exp_rsp;
    logic                    exp_err;
    logic                    exp_store;
    logic [31:0]             exp_value;
    int                      exp_id;
    logic                    report;
    int                      pending;
    int                      tests_run;
    int                      error_count;

    row_t        rows[$];
    logic [31:0] shadow [2**`DMEM_DEPTH_LOG2]; // Expected SRAM contents
    logic [31:0] rand_state;
    int          n_rows  = 0;
    int          n_tests = 0;

    always #(PERIOD / 2) clk = ~clk;

    dmem_top dmem_top_i (.*);

    dmem_checker dmem_checker_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Field at the byte offset extended by its top bit or by zero
    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] size,
                                               input logic [1:0] off, input logic sgn);
        logic [31:0] lane;
        lane = word >> (8 * off);
        if (size == MEM_BYTE) begin
            return {{24{sgn & lane[7]}}, lane[7:0]};
        end else if (size == MEM_HALF) begin
            return {{16{sgn & lane[15]}}, lane[15:0]};
        end
        return word;
    endfunction

    task automatic add_row(input logic store, input logic [1:0] size, input logic sgn,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [1:0] outcome, input logic [31:0] value);
        rows.push_back({store, size, sgn, addr, wdata, outcome, value});
        if (outcome != OUT_NONE) begin
            n_tests++;
        end
    endtask

    task automatic store(input logic [1:0] size, input logic [31:0] addr,
                         input logic [31:0] data);
        logic [4:0]  sh;
        logic [31:0] lanes;
        sh = {addr[1:0], 3'b000};
        if (size == MEM_WORD) begin
            lanes = 32'hFFFF_FFFF;
        end else if (size == MEM_HALF) begin
            lanes = 32'h0000_FFFF << sh;
        end else begin
            lanes = 32'h0000_00FF << sh;
        end
        shadow[addr[11:2]] = (shadow[addr[11:2]] & ~lanes) | ((data << sh) & lanes);
        add_row(1'b1, size, 1'b0, addr, data, OUT_NONE, '0);
    endtask

    task automatic load(input logic [1:0] size, input logic sgn, input logic [31:0] addr);
        add_row(1'b0, size, sgn, addr, '0, OUT_DATA,
                load_value(shadow[addr[11:2]], size, addr[1:0], sgn));
    endtask

    // Faulting access leaves memory as it is
    task automatic bad_access(input logic st, input logic [1:0] size, input logic [31:0] addr);
        rand_state = lcg_next(rand_state);
        add_row(st, size, 1'b0, addr, rand_state, OUT_ERR, addr);
    endtask

    task automatic build_table();
        logic [31:0] fill_addr [4];
        fill_addr = '{32'h100, 32'h104, 32'h108, 32'hFFC};
        rand_state = 32'd49;
        for (int k = 0; k < 4; k++) begin
            rand_state = lcg_next(rand_state);
            store(MEM_WORD, fill_addr[k], rand_state);
        end
        store(MEM_WORD, 32'h10C, 32'h80F0_7F15); // Both sign cases in bytes and halves
        for (int k = 0; k < 4; k++) begin
            load(MEM_WORD, 1'b0, fill_addr[k]);
        end
        for (int k = 0; k < 4; k++) begin
            rand_state = lcg_next(rand_state);
            store(MEM_BYTE, 32'h104 + k, rand_state);
            load(MEM_WORD, 1'b0, 32'h104);
        end
        for (int k = 0; k < 4; k++) begin
            load(MEM_BYTE, 1'b1, 32'h10C + k);
            load(MEM_BYTE, 1'b0, 32'h10C + k);
            load(MEM_BYTE, 1'b1, 32'h100 + k);
        end
        for (int k = 0; k < 4; k += 2) begin
            load(MEM_HALF, 1'b1, 32'h10C + k);
            load(MEM_HALF, 1'b0, 32'h10C + k);
            load(MEM_HALF, 1'b1, 32'hFFC + k);
        end
        bad_access(1'b0, MEM_HALF, 32'h101);
        bad_access(1'b0, MEM_HALF, 32'h103);
        bad_access(1'b1, MEM_HALF, 32'h105);
        bad_access(1'b1, MEM_HALF, 32'h107);
        bad_access(1'b0, MEM_WORD, 32'h102);
        bad_access(1'b1, MEM_WORD, 32'h101);
        bad_access(1'b1, MEM_WORD, 32'h10B);
        bad_access(1'b0, MEM_RSVD, 32'h100);
        bad_access(1'b1, MEM_RSVD, 32'h108);
        for (int k = 0; k < 4; k++) begin
            load(MEM_WORD, 1'b0, 32'h100 + 4 * k);
        end
        // Mixed sizes on consecutive cycles
        for (int k = 0; k < 4; k++) begin
            load(MEM_WORD, 1'b0, fill_addr[k]);
            load(MEM_HALF, 1'b1, fill_addr[k] + 2);
            load(MEM_BYTE, 1'b0, fill_addr[k] + 3 - k);
        end
        n_rows = rows.size();
    endtask

    task automatic idle();
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_size   = MEM_BYTE;
        req_signed = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        exp_rsp    = 1'b0;
        exp_err    = 1'b0;
        exp_store  = 1'b0;
        exp_value  = '0;
    endtask

    task automatic drive_row(input int idx);
        row_t r;
        r = rows[idx];
        req_valid  = 1'b1;
        req_store  = r.store;
        req_size   = mem_size_e'(r.size);
        req_signed = r.sgn;
        req_addr   = r.addr;
        req_wdata  = r.wdata;
        exp_rsp    = (r.outcome == OUT_DATA);
        exp_err    = (r.outcome == OUT_ERR);
        exp_store  = r.store;
        exp_value  = r.value;
        exp_id     = idx;
    endtask

    initial begin
        rst    = 1'b1;
        report = 1'b0;
        exp_id = 0;
        idle();
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            drive_row(i);
            @(negedge clk);
        end
        idle();
        wait (pending == 0);
        @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        if (error_count == 0 && tests_run == n_tests) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (n_rows > 0);
        #((n_rows + RST_CYCLES + MARGIN) * PERIOD);
        $display("Watchdog expired at %0t with %0d outcomes still pending", $time, pending);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/dmem_pkg.sv
verilog/sbus_if.sv
verilog/lsu_request.sv
verilog/sbus_to_sram.sv
verilog/sram_bank.sv
verilog/load_align.sv
verilog/dmem_top.sv
verif/dmem_checker.sv
verif/dmem_tb.sv

//--- Bender.yml
package:
  name: dmem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dmem_pkg.sv
      - verilog/sbus_if.sv
      - verilog/lsu_request.sv
      - verilog/sbus_to_sram.sv
      - verilog/sram_bank.sv
      - verilog/load_align.sv
      - verilog/dmem_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verif/dmem_checker.sv
      - verif/dmem_tb.sv
